// File: common/roulette_pkg.sv
package roulette_pkg;

	// controller states, exported on o_state
	typedef enum logic [3:0] {
		ST_IDLE      = 4'd0,
		ST_LOAD      = 4'd1,
		ST_WAIT_TURN = 4'd2,
		ST_SHOOT     = 4'd3,
		ST_RESOLVE   = 4'd4,
		ST_WAIT_LOAD = 4'd5,
		ST_WAIT_DONE = 4'd6,
		ST_DONE      = 4'd7
	} game_state_e;

	// shot target opcode
	typedef enum logic [1:0] {
		OP_NONE     = 2'd0,
		OP_SELF     = 2'd1,
		OP_OPPONENT = 2'd2
	} shot_op_e;

	// magazine geometry
	localparam int MAG_DEPTH = 8;
	localparam int IDX_W     = $clog2(MAG_DEPTH);
	localparam int HP_W      = 3;
	localparam int PTR_W     = 4;

	// round size cycling, entry 0 only used on the first load of a game
	localparam int RIDX_W    = 2;
	localparam int ROUND_CNT = 4;
	localparam logic [PTR_W-1:0] ROUND_SIZES [ROUND_CNT] = '{4'd2, 4'd4, 4'd6, 4'd8};

	// shell generator
	localparam int              LFSR_W    = 16;
	localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;

	// winner codes
	localparam logic [1:0] WIN_NONE = 2'b00;
	localparam logic [1:0] WIN_P0   = 2'b01;
	localparam logic [1:0] WIN_P1   = 2'b10;

endpackage

// File: hdl/magazine_gen.sv
`timescale 1ns/1ps

module magazine_gen import roulette_pkg::*; #(
	parameter logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1
) (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_new_game,
	input  logic                 i_load_stb,
	output logic [MAG_DEPTH-1:0] o_bitmap,
	output logic [PTR_W-1:0]     o_round_size
);

	logic [LFSR_W-1:0] lfsr_r;
	logic [RIDX_W-1:0] idx_r;
	logic [PTR_W-1:0]  size;

	// galois lfsr, free running
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lfsr_r <= LFSR_SEED;
		end else if (lfsr_r[0]) begin
			lfsr_r <= {1'b0, lfsr_r[LFSR_W-1:1]} ^ LFSR_TAPS;
		end else begin
			lfsr_r <= {1'b0, lfsr_r[LFSR_W-1:1]};
		end
	end

	// index of the size used by the next load
	// 0 on the first load, then 1, 2, 3, 1, ...
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			idx_r <= '0;
		end else if (i_new_game) begin
			idx_r <= '0;
		end else if (i_load_stb) begin
			if (idx_r == RIDX_W'(ROUND_CNT - 1)) begin
				idx_r <= RIDX_W'(1);
			end else begin
				idx_r <= idx_r + 1'b1;
			end
		end
	end

	assign size         = ROUND_SIZES[idx_r];
	assign o_round_size = size;

	// keep only the slots that belong to this round
	always_comb begin
		for (int i = 0; i < MAG_DEPTH; i++) begin
			o_bitmap[i] = lfsr_r[i] && (PTR_W'(i) < size);
		end
	end

endmodule

// File: game_core/shot_decode.sv
`timescale 1ns/1ps

module shot_decode import roulette_pkg::*; (
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_await_shot,
	input  logic     i_shoot_trigger,
	input  logic     i_shoot_select,
	output shot_op_e o_shot_op,
	output logic     o_shot_valid
);

	logic accept;

	// one shot per turn, a second trigger right behind the first is dropped
	assign accept = i_await_shot && i_shoot_trigger && !o_shot_valid;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_shot_op    <= OP_NONE;
			o_shot_valid <= 1'b0;
		end else begin
			o_shot_valid <= accept;
			if (accept) begin
				// select 1 aims at the other player
				o_shot_op <= i_shoot_select ? OP_OPPONENT : OP_SELF;
			end
		end
	end

endmodule

// File: game_core/turn_controller.sv
`timescale 1ns/1ps

module turn_controller import roulette_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_start,
	input  logic        i_uart_done,
	input  logic        i_shot_valid,
	input  logic        i_keep_turn,
	input  logic        i_mag_empty,
	input  logic        i_game_over,
	output game_state_e o_state,
	output logic        o_player,
	output logic        o_new_game,
	output logic        o_load_stb,
	output logic        o_await_shot,
	output logic        o_resolve_stb
);

	game_state_e state_r;
	game_state_e state_nxt;
	logic        player_r;
	logic        player_nxt;
	logic        start_game;

	// start is honoured before the first game and after a finished one
	assign start_game = i_start && (state_r == ST_IDLE || state_r == ST_DONE);

	always_comb begin
		state_nxt  = state_r;
		player_nxt = player_r;
		case (state_r)
			ST_IDLE, ST_DONE: begin
				if (start_game) begin
					state_nxt  = ST_LOAD;
					player_nxt = 1'b0;
				end
			end
			ST_LOAD: begin
				state_nxt = ST_WAIT_TURN;
			end
			ST_WAIT_TURN: begin
				if (i_uart_done) begin
					state_nxt = ST_SHOOT;
				end
			end
			ST_SHOOT: begin
				if (i_shot_valid) begin
					state_nxt = ST_RESOLVE;
				end
			end
			ST_RESOLVE: begin
				// game over wins over an empty magazine
				if (i_game_over) begin
					state_nxt = ST_WAIT_DONE;
				end else if (i_mag_empty) begin
					state_nxt = ST_WAIT_LOAD;
				end else begin
					state_nxt = ST_WAIT_TURN;
				end
				if (!i_keep_turn) begin
					player_nxt = ~player_r;
				end
			end
			ST_WAIT_LOAD: begin
				if (i_uart_done) begin
					state_nxt = ST_LOAD;
				end
			end
			ST_WAIT_DONE: begin
				if (i_uart_done) begin
					state_nxt = ST_DONE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r  <= ST_IDLE;
			player_r <= 1'b0;
		end else begin
			state_r  <= state_nxt;
			player_r <= player_nxt;
		end
	end

	assign o_state       = state_r;
	assign o_player      = player_r;
	assign o_new_game    = start_game;
	assign o_load_stb    = (state_r == ST_LOAD);
	assign o_await_shot  = (state_r == ST_SHOOT);
	assign o_resolve_stb = (state_r == ST_RESOLVE);

endmodule

// File: game_core/shot_execute.sv
`timescale 1ns/1ps

module shot_execute import roulette_pkg::*; #(
	parameter logic [HP_W-1:0] INIT_HP = 3'd4
) (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_new_game,
	input  logic                 i_load_stb,
	input  logic                 i_resolve_stb,
	input  logic                 i_player,
	input  shot_op_e             i_shot_op,
	input  logic [MAG_DEPTH-1:0] i_bitmap,
	input  logic [PTR_W-1:0]     i_round_size,
	output logic [MAG_DEPTH-1:0] o_bitmap,
	output logic [PTR_W-1:0]     o_ptr,
	output logic [PTR_W-1:0]     o_round_size,
	output logic [HP_W-1:0]      o_hp_p0,
	output logic [HP_W-1:0]      o_hp_p1,
	output logic                 o_shock,
	output logic                 o_keep_turn,
	output logic                 o_mag_empty,
	output logic                 o_game_over
);

	logic [MAG_DEPTH-1:0] bitmap_r;
	logic [PTR_W-1:0]     ptr_r;
	logic [PTR_W-1:0]     size_r;
	logic [HP_W-1:0]      hp_p0_r;
	logic [HP_W-1:0]      hp_p1_r;
	logic                 shock_r;
	logic                 keep_r;
	logic                 live;
	logic                 target;
	logic                 keep_now;
	logic [PTR_W-1:0]     ptr_nxt;
	logic [HP_W-1:0]      hp_p0_nxt;
	logic [HP_W-1:0]      hp_p1_nxt;

	// shell under the pointer, and who it is aimed at
	assign live   = bitmap_r[ptr_r[IDX_W-1:0]];
	assign target = (i_shot_op == OP_OPPONENT) ? ~i_player : i_player;

	// outcome of the shot being resolved, clamped at zero
	always_comb begin
		hp_p0_nxt = hp_p0_r;
		hp_p1_nxt = hp_p1_r;
		if (i_resolve_stb && live) begin
			if (!target && hp_p0_r != '0) begin
				hp_p0_nxt = hp_p0_r - 1'b1;
			end
			if (target && hp_p1_r != '0) begin
				hp_p1_nxt = hp_p1_r - 1'b1;
			end
		end
	end

	assign ptr_nxt  = i_resolve_stb ? ptr_r + 1'b1 : ptr_r;
	assign keep_now = (i_shot_op == OP_SELF) && !live;

	// flags already show the result while resolve_stb is high, and hold after
	assign o_keep_turn = i_resolve_stb ? keep_now : keep_r;
	assign o_mag_empty = (ptr_nxt == size_r);
	assign o_game_over = (hp_p0_nxt == '0) || (hp_p1_nxt == '0);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bitmap_r <= '0;
			ptr_r    <= '0;
			size_r   <= '0;
			hp_p0_r  <= INIT_HP;
			hp_p1_r  <= INIT_HP;
			shock_r  <= 1'b0;
			keep_r   <= 1'b0;
		end else begin
			shock_r <= i_resolve_stb && live;
			if (i_new_game) begin
				hp_p0_r <= INIT_HP;
				hp_p1_r <= INIT_HP;
			end else begin
				hp_p0_r <= hp_p0_nxt;
				hp_p1_r <= hp_p1_nxt;
			end
			if (i_load_stb) begin
				bitmap_r <= i_bitmap;
				size_r   <= i_round_size;
				ptr_r    <= '0;
				keep_r   <= 1'b0;
			end else begin
				ptr_r <= ptr_nxt;
				if (i_resolve_stb) begin
					keep_r <= keep_now;
				end
			end
		end
	end

	assign o_bitmap     = bitmap_r;
	assign o_ptr        = ptr_r;
	assign o_round_size = size_r;
	assign o_hp_p0      = hp_p0_r;
	assign o_hp_p1      = hp_p1_r;
	assign o_shock      = shock_r;

endmodule

// File: hdl/shell_status.sv
`timescale 1ns/1ps

module shell_status import roulette_pkg::*; (
	input  logic [MAG_DEPTH-1:0] i_bitmap,
	input  logic [PTR_W-1:0]     i_ptr,
	input  logic [PTR_W-1:0]     i_round_size,
	input  logic [HP_W-1:0]      i_hp_p0,
	input  logic [HP_W-1:0]      i_hp_p1,
	output logic [PTR_W-1:0]     o_remaining,
	output logic [PTR_W-1:0]     o_filled,
	output logic [PTR_W-1:0]     o_empty,
	output logic [1:0]           o_winner
);

	logic [PTR_W-1:0] filled;

	// live shells still ahead of the pointer
	always_comb begin
		filled = '0;
		for (int i = 0; i < MAG_DEPTH; i++) begin
			if (i_bitmap[i] && PTR_W'(i) >= i_ptr && PTR_W'(i) < i_round_size) begin
				filled = filled + 1'b1;
			end
		end
	end

	assign o_filled    = filled;
	assign o_remaining = i_round_size - i_ptr;
	assign o_empty     = o_remaining - filled;

	always_comb begin
		if (i_hp_p1 == '0) begin
			o_winner = WIN_P0;
		end else if (i_hp_p0 == '0) begin
			o_winner = WIN_P1;
		end else begin
			o_winner = WIN_NONE;
		end
	end

endmodule

// File: hdl/roulette_top.sv
`timescale 1ns/1ps

module roulette_top import roulette_pkg::*; #(
	parameter logic [HP_W-1:0]   INIT_HP   = 3'd4,
	parameter logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1
) (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_start,
	input  logic                 i_uart_done,
	input  logic                 i_shoot_trigger,
	input  logic                 i_shoot_select,
	output game_state_e          o_state,
	output logic                 o_player,
	output logic [HP_W-1:0]      o_hp_p0,
	output logic [HP_W-1:0]      o_hp_p1,
	output logic [MAG_DEPTH-1:0] o_bullet_bitmap,
	output logic [PTR_W-1:0]     o_bullet_ptr,
	output logic [PTR_W-1:0]     o_total_bullet,
	output logic [PTR_W-1:0]     o_remaining,
	output logic [PTR_W-1:0]     o_filled,
	output logic [PTR_W-1:0]     o_empty,
	output logic [1:0]           o_winner,
	output logic                 o_shock
);

	logic                 new_game;
	logic                 load_stb;
	logic                 await_shot;
	logic                 resolve_stb;
	shot_op_e             shot_op;
	logic                 shot_valid;
	logic                 keep_turn;
	logic                 mag_empty;
	logic                 game_over;
	logic [MAG_DEPTH-1:0] gen_bitmap;
	logic [PTR_W-1:0]     gen_round_size;

	magazine_gen #(
		.LFSR_SEED(LFSR_SEED)
	) u_magazine_gen (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_new_game   (new_game),
		.i_load_stb   (load_stb),
		.o_bitmap     (gen_bitmap),
		.o_round_size (gen_round_size)
	);

	shot_decode u_shot_decode (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_await_shot    (await_shot),
		.i_shoot_trigger (i_shoot_trigger),
		.i_shoot_select  (i_shoot_select),
		.o_shot_op       (shot_op),
		.o_shot_valid    (shot_valid)
	);

	turn_controller u_turn_controller (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_start       (i_start),
		.i_uart_done   (i_uart_done),
		.i_shot_valid  (shot_valid),
		.i_keep_turn   (keep_turn),
		.i_mag_empty   (mag_empty),
		.i_game_over   (game_over),
		.o_state       (o_state),
		.o_player      (o_player),
		.o_new_game    (new_game),
		.o_load_stb    (load_stb),
		.o_await_shot  (await_shot),
		.o_resolve_stb (resolve_stb)
	);

	shot_execute #(
		.INIT_HP(INIT_HP)
	) u_shot_execute (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_new_game    (new_game),
		.i_load_stb    (load_stb),
		.i_resolve_stb (resolve_stb),
		.i_player      (o_player),
		.i_shot_op     (shot_op),
		.i_bitmap      (gen_bitmap),
		.i_round_size  (gen_round_size),
		.o_bitmap      (o_bullet_bitmap),
		.o_ptr         (o_bullet_ptr),
		.o_round_size  (o_total_bullet),
		.o_hp_p0       (o_hp_p0),
		.o_hp_p1       (o_hp_p1),
		.o_shock       (o_shock),
		.o_keep_turn   (keep_turn),
		.o_mag_empty   (mag_empty),
		.o_game_over   (game_over)
	);

	shell_status u_shell_status (
		.i_bitmap     (o_bullet_bitmap),
		.i_ptr        (o_bullet_ptr),
		.i_round_size (o_total_bullet),
		.i_hp_p0      (o_hp_p0),
		.i_hp_p1      (o_hp_p1),
		.o_remaining  (o_remaining),
		.o_filled     (o_filled),
		.o_empty      (o_empty),
		.o_winner     (o_winner)
	);

endmodule

// File: verification/roulette_checker.sv
`timescale 1ns/1ps

module roulette_checker import roulette_pkg::*; (
	input logic            i_clk,
	input logic            i_rst_n,
	input game_state_e     i_state,
	input logic            i_shock,
	input logic            i_new_game,
	input logic [HP_W-1:0] i_hp_p0,
	input logic [HP_W-1:0] i_hp_p1,
	input logic [PTR_W-1:0] i_ptr,
	input logic [PTR_W-1:0] i_total
);

	// shock is a single cycle pulse
	assert property (@(posedge i_clk) disable iff (!i_rst_n) i_shock |=> !i_shock)
		else $error("shock high for two cycles");

	// hit points only go up when a new game starts
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_new_game |=> (i_hp_p0 <= $past(i_hp_p0)) && (i_hp_p1 <= $past(i_hp_p1)))
		else $error("hit points increased outside a new game");

	assert property (@(posedge i_clk) $rose(i_rst_n) |-> (i_state == ST_IDLE))
		else $error("state not idle after reset");

	assert property (@(posedge i_clk) disable iff (!i_rst_n) (i_ptr <= i_total))
		else $error("shell pointer beyond round size");

endmodule

bind roulette_top roulette_checker u_checker (
	.i_clk      (i_clk),
	.i_rst_n    (i_rst_n),
	.i_state    (o_state),
	.i_shock    (o_shock),
	.i_new_game (new_game),
	.i_hp_p0    (o_hp_p0),
	.i_hp_p1    (o_hp_p1),
	.i_ptr      (o_bullet_ptr),
	.i_total    (o_total_bullet)
);

// File: verification/roulette_tb.sv
`timescale 1ns/1ps

module roulette_tb import roulette_pkg::*; ();

	localparam logic [HP_W-1:0] INIT_HP = 3'd4;
	localparam int STIM_WORDS = 128;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 start;
	logic                 uart_done;
	logic                 trigger;
	logic                 select;
	game_state_e          state;
	logic                 player;
	logic [HP_W-1:0]      hp_p0;
	logic [HP_W-1:0]      hp_p1;
	logic [MAG_DEPTH-1:0] bitmap;
	logic [PTR_W-1:0]     ptr;
	logic [PTR_W-1:0]     total;
	logic [PTR_W-1:0]     remaining;
	logic [PTR_W-1:0]     filled;
	logic [PTR_W-1:0]     empty;
	logic [1:0]           winner;
	logic                 shock;

	// two words per stimulus line, game number then target
	logic [3:0]           stim_mem [0:STIM_WORDS-1];
	int                   stim_count;
	bit                   stim_loaded;
	int                   error_count;
	int                   check_count;

	// reference model of the game
	int                   m_hp0;
	int                   m_hp1;
	int                   m_ptr;
	int                   m_total;
	int                   m_idx;
	logic [MAG_DEPTH-1:0] m_bitmap;
	logic                 m_player;

	roulette_top #(
		.INIT_HP   (INIT_HP),
		.LFSR_SEED (16'h5A3C)
	) u_dut (
		.i_clk           (clk),
		.i_rst_n         (rst_n),
		.i_start         (start),
		.i_uart_done     (uart_done),
		.i_shoot_trigger (trigger),
		.i_shoot_select  (select),
		.o_state         (state),
		.o_player        (player),
		.o_hp_p0         (hp_p0),
		.o_hp_p1         (hp_p1),
		.o_bullet_bitmap (bitmap),
		.o_bullet_ptr    (ptr),
		.o_total_bullet  (total),
		.o_remaining     (remaining),
		.o_filled        (filled),
		.o_empty         (empty),
		.o_winner        (winner),
		.o_shock         (shock)
	);

	always #2 clk = ~clk;

	// display pacing, done on about half of the cycles
	initial begin
		void'($urandom(32'h0f316f46));
		uart_done <= 1'b0;
		forever begin
			@(posedge clk);
			uart_done <= (($urandom % 2) == 0);
		end
	end

	task automatic compare(input string name, input int got, input int exp);
		check_count++;
		if (got != exp) begin
			error_count++;
			$display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	function automatic bit is_wait(input game_state_e s);
		return s == ST_WAIT_TURN || s == ST_WAIT_LOAD || s == ST_WAIT_DONE;
	endfunction

	task automatic check_counts();
		int live_left;
		live_left = 0;
		for (int i = m_ptr; i < m_total; i++) begin
			if (m_bitmap[i]) begin
				live_left++;
			end
		end
		compare("o_remaining", int'(remaining), m_total - m_ptr);
		compare("o_filled", int'(filled), live_left);
		compare("o_empty", int'(empty), m_total - m_ptr - live_left);
	endtask

	// called on a falling edge, returns on the falling edge that shows s
	task automatic wait_for_state(input game_state_e s);
		while (state != s) begin
			if (is_wait(state)) begin
				check_counts();
			end
			@(negedge clk);
		end
	endtask

	// state is ST_LOAD here, the magazine shows one cycle later
	task automatic load_magazine();
		@(negedge clk);
		m_bitmap = bitmap;
		m_total  = int'(ROUND_SIZES[m_idx]);
		m_ptr    = 0;
		compare("o_total_bullet", int'(total), m_total);
		compare("o_bullet_ptr", int'(ptr), 0);
		compare("o_bullet_bitmap above total", int'(bitmap >> m_total), 0);
		m_idx = (m_idx == 3) ? 1 : m_idx + 1;
	endtask

	task automatic start_game();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		wait_for_state(ST_LOAD);
		m_hp0    = int'(INIT_HP);
		m_hp1    = int'(INIT_HP);
		m_player = 1'b0;
		m_idx    = 0;
		load_magazine();
		compare("o_hp_p0", int'(hp_p0), m_hp0);
		compare("o_hp_p1", int'(hp_p1), m_hp1);
		compare("o_player", int'(player), 0);
		compare("o_winner", int'(winner), int'(WIN_NONE));
	endtask

	task automatic fire(input int sel);
		logic live;
		logic target;
		int   exp_state;
		wait_for_state(ST_SHOOT);
		live = m_bitmap[m_ptr];
		@(posedge clk);
		trigger <= 1'b1;
		select  <= sel[0];
		@(posedge clk);
		trigger <= 1'b0;
		@(negedge clk);
		wait_for_state(ST_RESOLVE);
		@(negedge clk);
		target = sel[0] ? !m_player : m_player;
		if (live && !target && m_hp0 > 0) begin
			m_hp0--;
		end
		if (live && target && m_hp1 > 0) begin
			m_hp1--;
		end
		m_ptr++;
		// only a blank at oneself keeps the turn
		if (live || sel[0]) begin
			m_player = !m_player;
		end
		if (m_hp0 == 0 || m_hp1 == 0) begin
			exp_state = int'(ST_WAIT_DONE);
		end else if (m_ptr == m_total) begin
			exp_state = int'(ST_WAIT_LOAD);
		end else begin
			exp_state = int'(ST_WAIT_TURN);
		end
		compare("o_hp_p0", int'(hp_p0), m_hp0);
		compare("o_hp_p1", int'(hp_p1), m_hp1);
		compare("o_bullet_ptr", int'(ptr), m_ptr);
		compare("o_player", int'(player), int'(m_player));
		compare("o_shock", int'(shock), int'(live));
		compare("o_state", int'(state), exp_state);
		check_counts();
		@(negedge clk);
		compare("o_shock", int'(shock), 0);
		if (exp_state == int'(ST_WAIT_LOAD)) begin
			wait_for_state(ST_LOAD);
			load_magazine();
		end
	endtask

	task automatic finish_game();
		wait_for_state(ST_DONE);
		compare("o_winner", int'(winner), (m_hp1 == 0) ? int'(WIN_P0) : int'(WIN_P1));
		// a trigger after the end must be ignored
		@(posedge clk);
		trigger <= 1'b1;
		select  <= 1'b1;
		@(posedge clk);
		trigger <= 1'b0;
		repeat (3) @(negedge clk);
		compare("o_state", int'(state), int'(ST_DONE));
		compare("o_hp_p0", int'(hp_p0), m_hp0);
		compare("o_hp_p1", int'(hp_p1), m_hp1);
		compare("o_bullet_ptr", int'(ptr), m_ptr);
	endtask

	task automatic run_game(input int t);
		int shots[$];
		int k;
		int errors_at_start;
		errors_at_start = error_count;
		for (int i = 0; i < stim_count; i++) begin
			if (int'(stim_mem[2*i]) == t) begin
				shots.push_back(int'(stim_mem[2*i+1][0]));
			end
		end
		if (shots.size() == 0) begin
			return;
		end
		start_game();
		k = 0;
		// replay the game's targets until someone runs out of hit points
		while (m_hp0 != 0 && m_hp1 != 0) begin
			fire(shots[k % shots.size()]);
			k++;
		end
		finish_game();
		$display("game %0d: %0d shots, %0d mismatches", t, k, error_count - errors_at_start);
	endtask

	initial begin
		int n_games;
		rst_n   <= 1'b0;
		start   <= 1'b0;
		trigger <= 1'b0;
		select  <= 1'b0;
		$readmemh("verification/roulette_stim.txt", stim_mem);
		stim_count = 0;
		n_games    = 0;
		// a line with game 0 ends the list
		while (stim_count < STIM_WORDS / 2 && !$isunknown(stim_mem[2*stim_count])
				&& stim_mem[2*stim_count] != 4'h0) begin
			if (int'(stim_mem[2*stim_count]) > n_games) begin
				n_games = int'(stim_mem[2*stim_count]);
			end
			stim_count++;
		end
		stim_loaded = 1'b1;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		for (int t = 1; t <= n_games; t++) begin
			run_game(t);
		end
		$display("%0d games, %0d checks, %0d errors", n_games, check_count, error_count);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// run limit scales with the number of stimulus lines
	initial begin
		int limit;
		wait (stim_loaded);
		limit = stim_count * 200;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the game did not finish", limit);
		$display("test failed");
		$finish;
	end

endmodule

// File: verification/roulette_stim.txt
// column 1: test game number (hex, 0 ends the list)
// column 2: shot target, 1 = opponent, 0 = self
1 1
1 0
1 1
1 1
1 0
2 0
2 0
2 1
2 0
3 1
3 1
3 1
3 0
4 0
4 1
4 0
4 1
0 0

// File: filelist.f
common/roulette_pkg.sv
hdl/magazine_gen.sv
game_core/shot_decode.sv
game_core/turn_controller.sv
game_core/shot_execute.sv
hdl/shell_status.sv
hdl/roulette_top.sv
verification/roulette_checker.sv
verification/roulette_tb.sv

// File: Makefile
# Verilator build and run for the roulette core

VERILATOR ?= verilator
TOP       ?= roulette_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "no pass line found in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
